// ==== source/ttc_lite_pkg.sv ====
// --------------------------------------
// shared types and register map for the
// single channel lite timer counter
// imported by the register block and the
// top level, other blocks use scoped names
// --------------------------------------

package ttc_lite_pkg;

  // --------------------------------------
  // register offsets on the peripheral bus
  // --------------------------------------
  localparam logic [7:0] ADDR_CLK_CTRL   = 8'h00;
  localparam logic [7:0] ADDR_CNTR_CTRL  = 8'h0C;
  localparam logic [7:0] ADDR_COUNT      = 8'h18;
  localparam logic [7:0] ADDR_INTERVAL   = 8'h24;
  localparam logic [7:0] ADDR_MATCH      = 8'h30;
  localparam logic [7:0] ADDR_INT_STATUS = 8'h3C;
  localparam logic [7:0] ADDR_INT_EN     = 8'h48;

  // clock control, bit 0 is prescale_en
  // prescale tick period 2**(prescale_val+1) source events
  typedef struct packed {
    logic       ext_falling;
    logic       ext_sel;
    logic [3:0] prescale_val;
    logic       prescale_en;
  } clk_ctrl_t;

  // counter control, bit 0 is count_dis
  // restart is a level, served once per rising edge
  typedef struct packed {
    logic restart;
    logic match_en;
    logic decrement;
    logic interval_mode;
    logic count_dis;
  } cntr_ctrl_t;

  // one cycle event pulses from the counter
  // same bit order as the interrupt status and enable registers
  typedef struct packed {
    logic overflow;
    logic match;
    logic interval;
  } cnt_events_t;

endpackage

// ==== source/ttc_count_rst_lite.sv ====
// --------------------------------------
// count reset block
// owns the clock control register and
// turns a fresh restart level into a
// single cycle drop of count_en
// --------------------------------------

`timescale 1ns/100ps

module ttc_count_rst_lite (
  input  logic                     pclk11,
  input  logic                     n_p_reset11,
  input  logic [6:0]               pwdata,
  input  logic                     clk_ctrl_sel,
  input  logic                     restart,
  output logic                     count_en,
  output ttc_lite_pkg::clk_ctrl_t  clk_ctrl
);

  // set once the current restart level has been served
  logic restart_seen;

  // --------------------------------------
  // restart edge to count enable pulse
  // --------------------------------------
  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      restart_seen <= 1'b0;
      // low for one cycle out of reset
      count_en     <= 1'b0;
    end
    else if (restart && !restart_seen)
    begin
      // fresh restart, clear prescaler and reload counter
      restart_seen <= 1'b1;
      count_en     <= 1'b0;
    end
    else
    begin
      // level held high does nothing more
      if (!restart)
      begin
        restart_seen <= 1'b0;
      end
      count_en <= 1'b1;
    end
  end

  // --------------------------------------
  // clock control register
  // --------------------------------------
  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      clk_ctrl <= '0;
    end
    else if (clk_ctrl_sel)
    begin
      clk_ctrl <= pwdata;
    end
  end

endmodule

// ==== source/ttc_clk_enable_lite.sv ====
// --------------------------------------
// count tick generation
// picks pclk11 or a synchronized edge of
// ext_clk as source event, then divides
// by an optional power of two prescaler
// tick is combinational, one per event
// --------------------------------------

`timescale 1ns/100ps

module ttc_clk_enable_lite (
  input  logic                     pclk11,
  input  logic                     n_p_reset11,
  input  logic                     ext_clk,
  input  ttc_lite_pkg::clk_ctrl_t  clk_ctrl,
  input  logic                     count_en,
  input  logic                     count_dis,
  output logic                     tick
);

  // two flop synchronizer plus one delay stage for edge detect
  logic        ext_sync1;
  logic        ext_sync2;
  logic        ext_dly;
  logic        ext_edge;
  logic        src_event;
  // prescaler state
  logic [15:0] ps_cnt;
  logic [15:0] ps_mask;
  logic [16:0] ps_period;
  logic        ps_wrap;

  // --------------------------------------
  // external clock synchronizer
  // --------------------------------------
  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      ext_sync1 <= 1'b0;
      ext_sync2 <= 1'b0;
      ext_dly   <= 1'b0;
    end
    else
    begin
      ext_sync1 <= ext_clk;
      ext_sync2 <= ext_sync1;
      ext_dly   <= ext_sync2;
    end
  end

  // edge chosen by ext_falling
  assign ext_edge  = clk_ctrl.ext_falling ? (ext_dly & ~ext_sync2) : (ext_sync2 & ~ext_dly);
  // pclk11 source gives an event every cycle
  assign src_event = clk_ctrl.ext_sel ? ext_edge : 1'b1;

  // mask of prescale_val+1 low bits
  assign ps_period = 17'd1 << ({1'b0, clk_ctrl.prescale_val} + 5'd1);
  assign ps_mask   = 16'(ps_period - 17'd1);
  assign ps_wrap   = (ps_cnt & ps_mask) == ps_mask;

  // --------------------------------------
  // prescale counter
  // --------------------------------------
  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      ps_cnt <= '0;
    end
    else if (!count_en)
    begin
      ps_cnt <= '0;
    end
    else if (src_event && clk_ctrl.prescale_en && !count_dis)
    begin
      // restart count after the last event of a period
      ps_cnt <= ps_wrap ? 16'd0 : ps_cnt + 16'd1;
    end
  end

  // prescaler off passes every event
  assign tick = count_en & ~count_dis & src_event & (~clk_ctrl.prescale_en | ps_wrap);

endmodule

// ==== source/ttc_counter_lite.sv ====
// --------------------------------------
// up/down counter for one timer channel
// overflow or interval wrap, optional
// match compare, one cycle event pulses
// registered alongside the count update
// --------------------------------------

`timescale 1ns/100ps

module ttc_counter_lite #(
  parameter int CNT_WIDTH = 16
) (
  input  logic                       pclk11,
  input  logic                       n_p_reset11,
  input  logic                       count_en,
  input  logic                       tick,
  input  logic                       interval_mode,
  input  logic                       decrement,
  input  logic                       match_en,
  input  logic [CNT_WIDTH-1:0]       interval,
  input  logic [CNT_WIDTH-1:0]       match_val,
  output logic [CNT_WIDTH-1:0]       count,
  output ttc_lite_pkg::cnt_events_t  events
);

  localparam logic [CNT_WIDTH-1:0] ALL_ONES = '1;
  localparam logic [CNT_WIDTH-1:0] ONE      = CNT_WIDTH'(1);

  logic [CNT_WIDTH-1:0] start_val;
  logic [CNT_WIDTH-1:0] next_count;
  logic                 wrap_interval;
  logic                 wrap_overflow;

  // --------------------------------------
  // reload value while count_en is low
  // --------------------------------------
  always_comb
  begin
    if (!decrement)
    begin
      start_val = '0;
    end
    else if (interval_mode)
    begin
      start_val = interval;
    end
    else
    begin
      start_val = ALL_ONES;
    end
  end

  // --------------------------------------
  // next value and wrap detect
  // --------------------------------------
  always_comb
  begin
    wrap_interval = 1'b0;
    wrap_overflow = 1'b0;
    if (decrement)
    begin
      // counting down, wrap at zero
      if (count == '0)
      begin
        wrap_interval = interval_mode;
        wrap_overflow = ~interval_mode;
        next_count    = interval_mode ? interval : ALL_ONES;
      end
      else
      begin
        next_count = count - ONE;
      end
    end
    else
    begin
      // counting up, wrap at interval or all ones
      if (interval_mode && count == interval)
      begin
        wrap_interval = 1'b1;
        next_count    = '0;
      end
      else if (!interval_mode && count == ALL_ONES)
      begin
        wrap_overflow = 1'b1;
        next_count    = '0;
      end
      else
      begin
        next_count = count + ONE;
      end
    end
  end

  // --------------------------------------
  // count register and event pulses
  // --------------------------------------
  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      count  <= '0;
      events <= '0;
    end
    else
    begin
      // pulses last a single cycle
      events <= '0;
      if (!count_en)
      begin
        count <= start_val;
      end
      else if (tick)
      begin
        count           <= next_count;
        events.interval <= wrap_interval;
        events.overflow <= wrap_overflow;
        // compare against the new value
        events.match    <= match_en && (next_count == match_val);
      end
    end
  end

endmodule

// ==== source/ttc_regs_lite.sv ====
// --------------------------------------
// register block on the peripheral bus
// decodes writes, keeps sticky interrupt
// status cleared on read, drives irq
// clock control lives in the count reset
// block and is only read back here
// --------------------------------------

`timescale 1ns/100ps

module ttc_regs_lite #(
  parameter int CNT_WIDTH = 16
) (
  input  logic                       pclk11,
  input  logic                       n_p_reset11,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [7:0]                 paddr,
  input  logic [31:0]                pwdata,
  input  logic [CNT_WIDTH-1:0]       count,
  input  ttc_lite_pkg::cnt_events_t  events,
  input  ttc_lite_pkg::clk_ctrl_t    clk_ctrl,
  output logic [31:0]                prdata,
  output logic                       clk_ctrl_sel,
  output ttc_lite_pkg::cntr_ctrl_t   cntr_ctrl,
  output logic [CNT_WIDTH-1:0]       interval,
  output logic [CNT_WIDTH-1:0]       match_val,
  output logic                       irq
);

  import ttc_lite_pkg::*;

  logic        wr_en;
  logic        rd_clr;
  cnt_events_t int_status;
  cnt_events_t int_en;

  // access phase strobes
  assign wr_en        = psel & penable & pwrite;
  assign rd_clr       = psel & penable & ~pwrite & (paddr == ADDR_INT_STATUS);
  assign clk_ctrl_sel = wr_en & (paddr == ADDR_CLK_CTRL);

  // --------------------------------------
  // writable registers
  // --------------------------------------
  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      cntr_ctrl <= '0;
      interval  <= '0;
      match_val <= '0;
      int_en    <= '0;
    end
    else if (wr_en)
    begin
      case (paddr)
        ADDR_CNTR_CTRL: cntr_ctrl <= pwdata[4:0];
        ADDR_INTERVAL:  interval  <= pwdata[CNT_WIDTH-1:0];
        ADDR_MATCH:     match_val <= pwdata[CNT_WIDTH-1:0];
        ADDR_INT_EN:    int_en    <= pwdata[2:0];
        default:        ;
      endcase
    end
  end

  // sticky status, a new event beats the read clear
  always_ff @(posedge pclk11 or negedge n_p_reset11)
  begin
    if (!n_p_reset11)
    begin
      int_status <= '0;
    end
    else
    begin
      int_status <= (rd_clr ? '0 : int_status) | events;
    end
  end

  assign irq = |(int_status & int_en);

  // --------------------------------------
  // read mux, zero when not selected
  // --------------------------------------
  always_comb
  begin
    prdata = '0;
    if (psel)
    begin
      case (paddr)
        ADDR_CLK_CTRL:   prdata = 32'(clk_ctrl);
        ADDR_CNTR_CTRL:  prdata = 32'(cntr_ctrl);
        ADDR_COUNT:      prdata = 32'(count);
        ADDR_INTERVAL:   prdata = 32'(interval);
        ADDR_MATCH:      prdata = 32'(match_val);
        ADDR_INT_STATUS: prdata = 32'(int_status);
        ADDR_INT_EN:     prdata = 32'(int_en);
        default:         prdata = '0;
      endcase
    end
  end

endmodule

// ==== source/ttc_timer_lite.sv ====
// --------------------------------------
// top level of the lite timer counter
// bus registers, count reset, tick
// generation and the counter itself
// CNT_WIDTH set here, 8 to 32 bits
// --------------------------------------

`timescale 1ns/100ps

module ttc_timer_lite #(
  parameter int CNT_WIDTH = 16
) (
  input  logic        pclk11,
  input  logic        n_p_reset11,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  input  logic        ext_clk,
  output logic [31:0] prdata,
  output logic        irq
);

  import ttc_lite_pkg::*;

  // block interconnect
  logic                 clk_ctrl_sel;
  logic                 count_en;
  logic                 tick;
  clk_ctrl_t            clk_ctrl;
  cntr_ctrl_t           cntr_ctrl;
  cnt_events_t          events;
  logic [CNT_WIDTH-1:0] interval;
  logic [CNT_WIDTH-1:0] match_val;
  logic [CNT_WIDTH-1:0] count;

  ttc_regs_lite #(
    .CNT_WIDTH (CNT_WIDTH)
  ) regs_i (
    .pclk11       (pclk11),
    .n_p_reset11  (n_p_reset11),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .count        (count),
    .events       (events),
    .clk_ctrl     (clk_ctrl),
    .prdata       (prdata),
    .clk_ctrl_sel (clk_ctrl_sel),
    .cntr_ctrl    (cntr_ctrl),
    .interval     (interval),
    .match_val    (match_val),
    .irq          (irq)
  );

  // clock control takes the low seven data bits
  ttc_count_rst_lite count_rst_i (
    .pclk11       (pclk11),
    .n_p_reset11  (n_p_reset11),
    .pwdata       (pwdata[6:0]),
    .clk_ctrl_sel (clk_ctrl_sel),
    .restart      (cntr_ctrl.restart),
    .count_en     (count_en),
    .clk_ctrl     (clk_ctrl)
  );

  ttc_clk_enable_lite clk_enable_i (
    .pclk11      (pclk11),
    .n_p_reset11 (n_p_reset11),
    .ext_clk     (ext_clk),
    .clk_ctrl    (clk_ctrl),
    .count_en    (count_en),
    .count_dis   (cntr_ctrl.count_dis),
    .tick        (tick)
  );

  ttc_counter_lite #(
    .CNT_WIDTH (CNT_WIDTH)
  ) counter_i (
    .pclk11        (pclk11),
    .n_p_reset11   (n_p_reset11),
    .count_en      (count_en),
    .tick          (tick),
    .interval_mode (cntr_ctrl.interval_mode),
    .decrement     (cntr_ctrl.decrement),
    .match_en      (cntr_ctrl.match_en),
    .interval      (interval),
    .match_val     (match_val),
    .count         (count),
    .events        (events)
  );

endmodule

// ==== tests/ttc_timer_lite_assert.sv ====
// --------------------------------------
// concurrent checks on count_en, restart
// and irq, bound into the count reset
// block and the register block
// --------------------------------------

`timescale 1ns/100ps

module ttc_timer_lite_assert (
  input logic                      pclk11,
  input logic                      n_p_reset11,
  input logic                      count_en,
  input logic                      restart,
  input logic                      irq,
  input ttc_lite_pkg::cnt_events_t events,
  input ttc_lite_pkg::cnt_events_t int_en
);

  // count_en only ever drops for a single cycle
  count_en_single_drop: assert property (
    @(posedge pclk11) disable iff (!n_p_reset11)
    !count_en |=> count_en
  ) else $error("count_en low for two cycles in a row");

  // fresh restart level serves one drop
  restart_drops_count_en: assert property (
    @(posedge pclk11) disable iff (!n_p_reset11)
    $rose(restart) |=> !count_en
  ) else $error("restart edge not followed by count_en low");

  // enabled event raises irq next cycle unless the enable moved
  event_raises_irq: assert property (
    @(posedge pclk11) disable iff (!n_p_reset11)
    |(events & int_en) |=> irq || (int_en != $past(int_en))
  ) else $error("enabled event did not raise irq");

endmodule

// count reset side, irq inputs tied off
bind ttc_count_rst_lite ttc_timer_lite_assert count_rst_chk (
  .pclk11 (pclk11), .n_p_reset11 (n_p_reset11), .count_en (count_en),
  .restart (restart), .irq (1'b0), .events (3'b000), .int_en (3'b000)
);

// register side, count enable inputs tied idle
bind ttc_regs_lite ttc_timer_lite_assert regs_chk (
  .pclk11 (pclk11), .n_p_reset11 (n_p_reset11), .count_en (1'b1),
  .restart (1'b0), .irq (irq), .events (events), .int_en (int_en)
);

// ==== tests/ttc_timer_lite_tb.sv ====
// --------------------------------------
// directed testbench for the lite timer
// counter, drives the peripheral bus and
// ext_clk, checks register readback,
// counting, events and the interrupt
// --------------------------------------

`timescale 1ns/100ps

module ttc_timer_lite_tb;

  import ttc_lite_pkg::*;

  localparam int CNT_WIDTH      = 16;
  // ext clock runs dominate, about 6000 cycles
  localparam int TIMEOUT_CYCLES = 20000;

  logic        pclk11;
  logic        n_p_reset11;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic        ext_clk;
  logic [31:0] prdata;
  logic        irq;
  logic [31:0] lfsr_state;
  int          cycle_count;

  ttc_timer_lite #(
    .CNT_WIDTH (CNT_WIDTH)
  ) dut_i (
    .pclk11      (pclk11),
    .n_p_reset11 (n_p_reset11),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .ext_clk     (ext_clk),
    .prdata      (prdata),
    .irq         (irq)
  );

  always #4 pclk11 = ~pclk11;

  // --------------------------------------
  // run limit and error exit
  // --------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "%s", why);
  endtask

  always @(posedge pclk11)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      abort_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  // --------------------------------------
  // bus cycles, setup then access
  // --------------------------------------
  task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
    @(posedge pclk11);
    psel    <= 1'b1;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge pclk11);
    penable <= 1'b1;
    // write edge
    @(posedge pclk11);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
    @(posedge pclk11);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge pclk11);
    penable <= 1'b1;
    // prdata settled mid access cycle
    @(negedge pclk11);
    data = prdata;
    @(posedge pclk11);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // --------------------------------------
  // compare tasks
  // --------------------------------------
  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("[FAIL] t=%0t %s expected 32'h%08h got 32'h%08h", $time, name, exp, act);
      abort_run("register value mismatch");
    end
  endtask

  task automatic check_range(input string name, input int lo, input int hi, input int act);
    if (act < lo || act > hi)
    begin
      $display("[FAIL] t=%0t %s expected %0d..%0d got %0d", $time, name, lo, hi, act);
      abort_run("count outside its window");
    end
  endtask

  task automatic check_clk_ctrl(input clk_ctrl_t exp, input clk_ctrl_t act);
    if (act !== exp)
    begin
      $display("[FAIL] t=%0t clk_ctrl expected 7'h%02h got 7'h%02h", $time, exp, act);
      abort_run("clock control mismatch");
    end
  endtask

  task automatic check_irq(input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("[FAIL] t=%0t irq expected %b got %b", $time, exp, act);
      abort_run("interrupt level mismatch");
    end
  endtask

  // drop restart then raise it again
  task automatic restart_counter(input logic [31:0] mode);
    bus_write(ADDR_CNTR_CTRL, mode);
    bus_write(ADDR_CNTR_CTRL, mode | 32'h10);
  endtask

  // --------------------------------------
  // directed tests
  // --------------------------------------
  task automatic readback_regs();
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [31:0] cnt0;
    wdata = rand_bits(32);
    bus_write(ADDR_CLK_CTRL, wdata);
    bus_read(ADDR_CLK_CTRL, rdata);
    check_clk_ctrl(clk_ctrl_t'(wdata[6:0]), clk_ctrl_t'(rdata[6:0]));
    check_word("prdata clk_ctrl", {25'd0, wdata[6:0]}, rdata);
    // restart stays low here
    wdata = rand_bits(32) & 32'hFFFF_FFEF;
    bus_write(ADDR_CNTR_CTRL, wdata);
    bus_read(ADDR_CNTR_CTRL, rdata);
    check_word("prdata cntr_ctrl", {27'd0, wdata[4:0]}, rdata);
    wdata = rand_bits(32);
    bus_write(ADDR_INTERVAL, wdata);
    bus_read(ADDR_INTERVAL, rdata);
    check_word("prdata interval", {16'd0, wdata[15:0]}, rdata);
    wdata = rand_bits(32);
    bus_write(ADDR_MATCH, wdata);
    bus_read(ADDR_MATCH, rdata);
    check_word("prdata match", {16'd0, wdata[15:0]}, rdata);
    wdata = rand_bits(32);
    bus_write(ADDR_INT_EN, wdata);
    bus_read(ADDR_INT_EN, rdata);
    check_word("prdata int_en", {29'd0, wdata[2:0]}, rdata);
    bus_write(ADDR_INT_EN, 32'd0);
    // holes in the map
    bus_read(8'h04, rdata);
    check_word("prdata 0x04", 32'd0, rdata);
    bus_read(8'h54, rdata);
    check_word("prdata 0x54", 32'd0, rdata);
    // count frozen, writes to it ignored
    bus_write(ADDR_CNTR_CTRL, 32'h1);
    bus_read(ADDR_COUNT, cnt0);
    bus_write(ADDR_COUNT, ~cnt0);
    bus_read(ADDR_COUNT, rdata);
    check_word("prdata count", cnt0, rdata);
  endtask

  task automatic free_count_restart();
    logic [31:0] rdata;
    int          wait_cycles;
    wait_cycles = 40 + int'(rand_bits(6));
    bus_write(ADDR_CLK_CTRL, 32'd0);
    restart_counter(32'd0);
    repeat (wait_cycles) @(posedge pclk11);
    bus_read(ADDR_COUNT, rdata);
    check_range("count", wait_cycles - 4, wait_cycles + 1, rdata);
    // second restart reloads zero
    restart_counter(32'd0);
    bus_read(ADDR_COUNT, rdata);
    check_range("count", 0, 3, rdata);
  endtask

  task automatic prescaled_count(input int pv);
    logic [31:0] rdata;
    int          exp_cnt;
    exp_cnt = 256 >> (pv + 1);
    bus_write(ADDR_CLK_CTRL, 32'(pv << 1) | 32'h1);
    restart_counter(32'd0);
    repeat (256) @(posedge pclk11);
    bus_read(ADDR_COUNT, rdata);
    check_range("count", exp_cnt - 1, exp_cnt + 1, rdata);
  endtask

  task automatic ext_clock_count(input logic falling);
    logic [31:0] rdata;
    int          periods;
    periods = 100 + int'(rand_bits(5));
    // ext_sel bit 5, ext_falling bit 6
    bus_write(ADDR_CLK_CTRL, {25'd0, falling, 6'b100000});
    restart_counter(32'd0);
    repeat (periods)
    begin
      repeat (10) @(posedge pclk11);
      ext_clk <= 1'b1;
      repeat (10) @(posedge pclk11);
      ext_clk <= 1'b0;
    end
    // synchronizer latency
    repeat (4) @(posedge pclk11);
    bus_read(ADDR_COUNT, rdata);
    check_range("count", periods - 1, periods + 1, rdata);
  endtask

  task automatic interval_match_events(input logic dec);
    logic [31:0] mode;
    logic [31:0] rdata;
    int          ival;
    int          mval;
    ival = 8 + int'(rand_bits(4));
    mval = 1 + int'(rand_bits(2));
    // match_en, decrement, interval_mode
    mode = {28'd0, 1'b1, dec, 1'b1, 1'b0};
    bus_write(ADDR_CLK_CTRL, 32'd0);
    bus_write(ADDR_INTERVAL, 32'(ival));
    bus_write(ADDR_MATCH, 32'(mval));
    // reload while held off, then clear old status
    restart_counter(mode | 32'h1);
    bus_read(ADDR_INT_STATUS, rdata);
    bus_write(ADDR_CNTR_CTRL, mode | 32'h10);
    repeat (ival + 3) @(posedge pclk11);
    // wrapped once, four steps past the wrap at sample time
    bus_read(ADDR_COUNT, rdata);
    check_word("count", dec ? 32'(ival - 4) : 32'd4, rdata);
    bus_read(ADDR_INT_STATUS, rdata);
    check_word("int_status", 32'h3, rdata);
    @(negedge pclk11);
    check_irq(1'b0, irq);
  endtask

  // all ones from a down count reload, then one up tick wraps
  task automatic raise_overflow();
    logic [31:0] rdata;
    restart_counter(32'h5);
    bus_write(ADDR_CNTR_CTRL, 32'h1);
    bus_read(ADDR_COUNT, rdata);
    check_word("count", 32'h0000_FFFF, rdata);
    bus_read(ADDR_INT_STATUS, rdata);
    bus_write(ADDR_CNTR_CTRL, 32'h0);
    bus_write(ADDR_CNTR_CTRL, 32'h1);
  endtask

  task automatic overflow_event();
    logic [31:0] rdata;
    raise_overflow();
    bus_read(ADDR_INT_STATUS, rdata);
    check_word("int_status", 32'h4, rdata);
  endtask

  task automatic irq_mask_and_clear();
    logic [31:0] rdata;
    logic [2:0]  en;
    en = 3'b100 | 3'(rand_bits(2));
    bus_write(ADDR_INT_EN, 32'd0);
    raise_overflow();
    @(negedge pclk11);
    check_irq(1'b0, irq);
    bus_write(ADDR_INT_EN, {29'd0, en});
    @(negedge pclk11);
    check_irq(1'b1, irq);
    // read returns the bits, then clears them
    bus_read(ADDR_INT_STATUS, rdata);
    check_word("int_status", 32'h4, rdata);
    bus_read(ADDR_INT_STATUS, rdata);
    check_word("int_status", 32'h0, rdata);
    @(negedge pclk11);
    check_irq(1'b0, irq);
  endtask

  // --------------------------------------
  // main sequence
  // --------------------------------------
  initial
  begin
    pclk11      = 1'b0;
    n_p_reset11 = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = 8'h00;
    pwdata      = 32'd0;
    ext_clk     = 1'b0;
    lfsr_state  = 32'h6708;
    cycle_count = 0;
    repeat (2) @(posedge pclk11);
    n_p_reset11 <= 1'b1;
    @(posedge pclk11);
    readback_regs();
    free_count_restart();
    prescaled_count(0);
    prescaled_count(2);
    prescaled_count(3);
    ext_clock_count(1'b0);
    ext_clock_count(1'b1);
    interval_match_events(1'b0);
    interval_match_events(1'b1);
    overflow_event();
    irq_mask_and_clear();
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== project.f ====
source/ttc_lite_pkg.sv
source/ttc_count_rst_lite.sv
source/ttc_clk_enable_lite.sv
source/ttc_counter_lite.sv
source/ttc_regs_lite.sv
source/ttc_timer_lite.sv
tests/ttc_timer_lite_assert.sv
tests/ttc_timer_lite_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lite timer testbench with Verilator
# exit status is 0 only when the run reports no failure

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f project.f \
    --top-module ttc_timer_lite_tb -o ttc_timer_lite_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/ttc_timer_lite_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

echo "simulation passed"
exit 0
